//--- scoreboard_ctrl.f
logic/scoreboard_pkg.sv
logic/fu_status_if.sv
logic/inst_decoder.sv
logic/fu_status_table.sv
logic/operand_arbiter.sv
logic/writeback_arbiter.sv
logic/scoreboard_ctrl.sv
tests/scoreboard_ctrl_props.sv
tests/scoreboard_ctrl_tb.sv

//--- tests/scoreboard_ctrl_tb.sv
`timescale 1ns/1ps

module scoreboard_ctrl_tb import scoreboard_pkg::*; ();

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    localparam int MAX_ROWS   = 64;

    // Unit bits {div, mul, alu} for enables and done pulses
    localparam logic [2:0] U_NONE = 3'b000;
    localparam logic [2:0] U_ALU  = 3'b001;
    localparam logic [2:0] U_MUL  = 3'b010;
    localparam logic [2:0] U_DIV  = 3'b100;

    // Set bit in the care mask checks that group
    localparam logic [2:0] CARE_OPND = 3'b001;
    localparam logic [2:0] CARE_CTRL = 3'b010;
    localparam logic [2:0] CARE_WB   = 3'b100;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [2:0]  done;
        logic [2:0]  care;
        logic        is_en;
        logic [2:0]  en;
        logic [3:0]  op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        use_pc;
        logic        use_imm;
        logic [31:0] pc_ctrl;
        logic [31:0] imm_ctrl;
        logic        wr;
        logic [1:0]  sel;
        logic [4:0]  rd;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [31:0]           inst;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       imm;
    logic                  alu_done;
    logic                  mul_done;
    logic                  div_done;
    logic                  is_en;
    logic                  alu_en;
    logic                  mul_en;
    logic                  div_en;
    alu_op_e               alu_op;
    mul_op_e               mul_op;
    div_op_e               div_op;
    logic                  alu_use_pc;
    logic                  alu_use_imm;
    logic [REG_ADDR_W-1:0] rs1_ctrl;
    logic [REG_ADDR_W-1:0] rs2_ctrl;
    logic [XLEN-1:0]       pc_ctrl;
    logic [XLEN-1:0]       imm_ctrl;
    logic                  reg_write;
    wb_sel_e               write_sel;
    logic [REG_ADDR_W-1:0] rd_ctrl;

    row_t   rows [0:MAX_ROWS-1];
    int     n_rows;
    int     table_len;
    int     cur_row;
    integer seed = 84551;

    scoreboard_ctrl #(
        .XLEN (XLEN)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .pc          (pc),
        .imm         (imm),
        .alu_done    (alu_done),
        .mul_done    (mul_done),
        .div_done    (div_done),
        .is_en       (is_en),
        .alu_en      (alu_en),
        .mul_en      (mul_en),
        .div_en      (div_en),
        .alu_op      (alu_op),
        .mul_op      (mul_op),
        .div_op      (div_op),
        .alu_use_pc  (alu_use_pc),
        .alu_use_imm (alu_use_imm),
        .rs1_ctrl    (rs1_ctrl),
        .rs2_ctrl    (rs2_ctrl),
        .pc_ctrl     (pc_ctrl),
        .imm_ctrl    (imm_ctrl),
        .reg_write   (reg_write),
        .write_sel   (write_sel),
        .rd_ctrl     (rd_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (table_len != 0);
        #((RST_CYCLES + table_len + 10) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish in time");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    // RV32 instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm20, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm20, rd, opc};
    endfunction

    task automatic add_row(input logic [31:0] i, input logic [31:0] p, input logic [31:0] m,
                           input logic [2:0] done, input logic exp_is_en);
        row_t r;
        r          = '{default: '0};
        r.inst     = i;
        r.pc       = p;
        r.imm      = m;
        r.done     = done;
        r.is_en    = exp_is_en;
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic add_idle(input logic [2:0] done);
        add_row(32'h0, 32'h0, 32'h0, done, 1'b1);
    endtask

    task automatic expect_read(input logic [2:0] en, input logic [3:0] op,
                               input logic [4:0] rs1, input logic [4:0] rs2);
        rows[n_rows-1].en   = en;
        rows[n_rows-1].op   = op;
        rows[n_rows-1].rs1  = rs1;
        rows[n_rows-1].rs2  = rs2;
        rows[n_rows-1].care = rows[n_rows-1].care | CARE_OPND;
    endtask

    task automatic mark_alu_ctrl(input logic use_pc_e, input logic use_imm_e,
                                 input logic [31:0] pc_e, input logic [31:0] imm_e);
        rows[n_rows-1].use_pc   = use_pc_e;
        rows[n_rows-1].use_imm  = use_imm_e;
        rows[n_rows-1].pc_ctrl  = pc_e;
        rows[n_rows-1].imm_ctrl = imm_e;
        rows[n_rows-1].care     = rows[n_rows-1].care | CARE_CTRL;
    endtask

    task automatic expect_write(input logic [1:0] sel, input logic [4:0] rd);
        rows[n_rows-1].wr   = 1'b1;
        rows[n_rows-1].sel  = sel;
        rows[n_rows-1].rd   = rd;
        rows[n_rows-1].care = rows[n_rows-1].care | CARE_WB;
    endtask

    task automatic build_table();
        logic [4:0]  rd_a;
        logic [4:0]  rs1_a;
        logic [4:0]  rs2_a;
        logic [31:0] add_a;
        logic [31:0] mul_a;
        logic [31:0] mul_b;
        logic [31:0] div_a;
        logic [31:0] addi_a;
        logic [31:0] divu_a;
        logic [31:0] and_a;
        logic [31:0] mul_c;
        logic [31:0] rem_a;
        logic [31:0] mulh_a;
        logic [31:0] add_b;
        rd_a   = 5'($random(seed));
        rs1_a  = 5'($random(seed));
        rs2_a  = 5'($random(seed));
        if (rd_a == 5'd0) rd_a = 5'd1;
        add_a  = r_type(7'h00, rs2_a, rs1_a, 3'd0, rd_a);
        mul_a  = r_type(7'h01, 5'd2, 5'd1, 3'd0, 5'd5);
        mul_b  = r_type(7'h01, 5'd4, 5'd3, 3'd3, 5'd6);
        div_a  = r_type(7'h01, 5'd9, 5'd8, 3'd4, 5'd7);
        addi_a = i_type(12'd5, 5'd1, 3'd0, 5'd7);
        divu_a = r_type(7'h01, 5'd12, 5'd11, 3'd5, 5'd10);
        and_a  = r_type(7'h00, 5'd14, 5'd10, 3'd7, 5'd13);
        mul_c  = r_type(7'h01, 5'd17, 5'd16, 3'd0, 5'd15);
        rem_a  = r_type(7'h01, 5'd2, 5'd1, 3'd6, 5'd21);
        mulh_a = r_type(7'h01, 5'd21, 5'd20, 3'd1, 5'd22);
        add_b  = r_type(7'h00, 5'd4, 5'd3, 3'd0, 5'd20);

        add_idle(U_NONE);
        // Lone ADD on random registers
        add_row(add_a, 32'h100, 32'h0, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_ADD, rs1_a, rs2_a);
        mark_alu_ctrl(1'b0, 1'b0, 32'h100, 32'h0);
        add_idle(U_ALU);
        add_idle(U_NONE);
        expect_write(WB_ALU, rd_a);
        add_idle(U_NONE);
        // Second MUL waits for the unit
        add_row(mul_a, 32'h0, 32'h0, U_NONE, 1'b1);
        add_row(mul_b, 32'h0, 32'h0, U_NONE, 1'b0);
        expect_read(U_MUL, MUL_MUL, 5'd1, 5'd2);
        add_row(mul_b, 32'h0, 32'h0, U_MUL, 1'b0);
        add_row(mul_b, 32'h0, 32'h0, U_NONE, 1'b0);
        expect_write(WB_MUL, 5'd5);
        add_row(mul_b, 32'h0, 32'h0, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_MUL, MUL_MULHU, 5'd3, 5'd4);
        add_idle(U_MUL);
        add_idle(U_NONE);
        expect_write(WB_MUL, 5'd6);
        // ADDI to x7 while DIV owns x7
        add_row(div_a, 32'h0, 32'h0, U_NONE, 1'b1);
        add_row(addi_a, 32'h300, 32'h5, U_NONE, 1'b0);
        expect_read(U_DIV, DIV_DIV, 5'd8, 5'd9);
        add_row(addi_a, 32'h300, 32'h5, U_DIV, 1'b0);
        add_row(addi_a, 32'h300, 32'h5, U_NONE, 1'b0);
        expect_write(WB_DIV, 5'd7);
        add_row(addi_a, 32'h300, 32'h5, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_ADD, 5'd1, 5'd0);
        mark_alu_ctrl(1'b0, 1'b1, 32'h300, 32'h5);
        add_idle(U_ALU);
        add_idle(U_NONE);
        expect_write(WB_ALU, 5'd7);
        // AND waits on x10 while the MUL behind it reads first
        add_row(divu_a, 32'h0, 32'h0, U_NONE, 1'b1);
        add_row(and_a, 32'h0, 32'h0, U_NONE, 1'b1);
        expect_read(U_DIV, DIV_DIVU, 5'd11, 5'd12);
        add_row(mul_c, 32'h0, 32'h0, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_MUL, MUL_MUL, 5'd16, 5'd17);
        add_idle(U_DIV);
        add_idle(U_NONE);
        expect_write(WB_DIV, 5'd10);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_AND, 5'd10, 5'd14);
        add_idle(U_ALU | U_MUL);
        add_idle(U_NONE);
        expect_write(WB_ALU, 5'd13);
        add_idle(U_NONE);
        expect_write(WB_MUL, 5'd15);
        add_idle(U_NONE);
        // ALU result to x20 held until the MUL has read x20
        add_row(rem_a, 32'h0, 32'h0, U_NONE, 1'b1);
        add_row(mulh_a, 32'h0, 32'h0, U_NONE, 1'b1);
        expect_read(U_DIV, DIV_REM, 5'd1, 5'd2);
        add_row(add_b, 32'h0, 32'h0, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_ADD, 5'd3, 5'd4);
        add_idle(U_ALU);
        add_idle(U_DIV);
        add_idle(U_NONE);
        expect_write(WB_DIV, 5'd21);
        add_idle(U_NONE);
        expect_read(U_MUL, MUL_MULH, 5'd20, 5'd21);
        add_idle(U_NONE);
        expect_write(WB_ALU, 5'd20);
        add_idle(U_MUL);
        add_idle(U_NONE);
        expect_write(WB_MUL, 5'd22);
        // AUIPC and LUI with pc and imm changed after issue
        add_row(u_type(20'h12345, 5'd23, 7'b0010111), 32'h1000, 32'h12345000, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_ADD, 5'd0, 5'd0);
        mark_alu_ctrl(1'b1, 1'b1, 32'h1000, 32'h12345000);
        add_idle(U_ALU);
        add_idle(U_NONE);
        expect_write(WB_ALU, 5'd23);
        add_row(u_type(20'habcde, 5'd24, 7'b0110111), 32'h2000, 32'habcde000, U_NONE, 1'b1);
        add_idle(U_NONE);
        expect_read(U_ALU, ALU_LUI, 5'd0, 5'd0);
        mark_alu_ctrl(1'b0, 1'b1, 32'h2000, 32'habcde000);
        add_idle(U_ALU);
        add_idle(U_NONE);
        expect_write(WB_ALU, 5'd24);
        // A load is not kept, so it goes through and nothing starts
        add_row(32'h0000_2083, 32'h0, 32'h0, U_NONE, 1'b1);
        add_idle(U_NONE);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0d ns: row %0d %s is %0h, expected %0h",
                     $time, cur_row, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_row(input row_t r);
        inst = r.inst;
        pc   = r.pc;
        imm  = r.imm;
        {div_done, mul_done, alu_done} = r.done;
    endtask

    task automatic check_row(input row_t r);
        check_value("is_en", 32'(is_en), 32'(r.is_en));
        check_value("enables", 32'({div_en, mul_en, alu_en}), 32'(r.en));
        check_value("reg_write", 32'(reg_write), 32'(r.wr));
        if ((r.care & CARE_OPND) != 0) begin
            case (r.en)
                U_ALU:   check_value("alu_op", 32'(alu_op), 32'(r.op));
                U_MUL:   check_value("mul_op", 32'(mul_op), 32'(r.op));
                U_DIV:   check_value("div_op", 32'(div_op), 32'(r.op));
                default: ;
            endcase
            check_value("rs1_ctrl", 32'(rs1_ctrl), 32'(r.rs1));
            check_value("rs2_ctrl", 32'(rs2_ctrl), 32'(r.rs2));
        end
        if ((r.care & CARE_CTRL) != 0) begin
            check_value("alu_use_pc", 32'(alu_use_pc), 32'(r.use_pc));
            check_value("alu_use_imm", 32'(alu_use_imm), 32'(r.use_imm));
            check_value("pc_ctrl", pc_ctrl, r.pc_ctrl);
            check_value("imm_ctrl", imm_ctrl, r.imm_ctrl);
        end
        if ((r.care & CARE_WB) != 0) begin
            check_value("write_sel", 32'(write_sel), 32'(r.sel));
            check_value("rd_ctrl", 32'(rd_ctrl), 32'(r.rd));
        end
    endtask

    initial begin
        rst       = 1'b1;
        inst      = '0;
        pc        = '0;
        imm       = '0;
        alu_done  = 1'b0;
        mul_done  = 1'b0;
        div_done  = 1'b0;
        n_rows    = 0;
        table_len = 0;
        cur_row   = 0;
        build_table();
        table_len = n_rows;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Outputs checked mid-cycle before the next rising edge
        for (int i = 0; i < n_rows; i++) begin
            @(negedge clk);
            cur_row = i;
            drive_row(rows[i]);
            #2;
            check_row(rows[i]);
        end

        @(negedge clk);
        if (u_dut.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("Assertion failures in the bound property checks");
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- tests/scoreboard_ctrl_props.sv
`timescale 1ns/1ps

module scoreboard_ctrl_props import scoreboard_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic                  alu_en,
    input logic                  mul_en,
    input logic                  div_en,
    input logic                  reg_write,
    input logic [REG_ADDR_W-1:0] rd_ctrl
);

    // Failure count, seen by the testbench
    int fail_count = 0;

    // One operand read per cycle
    one_reader: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_en, mul_en, div_en}))
    else begin
        fail_count++;
        $error("more than one unit enable in the same cycle");
    end

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        reg_write |-> (rd_ctrl != '0))
    else begin
        fail_count++;
        $error("register write to x0");
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !(alu_en || mul_en || div_en || reg_write))
    else begin
        fail_count++;
        $error("enable or register write during reset");
    end

endmodule

bind scoreboard_ctrl scoreboard_ctrl_props u_props (
    .clk       (clk),
    .rst       (rst),
    .alu_en    (alu_en),
    .mul_en    (mul_en),
    .div_en    (div_en),
    .reg_write (reg_write),
    .rd_ctrl   (rd_ctrl)
);

//--- logic/scoreboard_ctrl.sv
`timescale 1ns/1ps

module scoreboard_ctrl import scoreboard_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           inst,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       imm,
    input  logic                  alu_done,
    input  logic                  mul_done,
    input  logic                  div_done,
    output logic                  is_en,
    output logic                  alu_en,
    output logic                  mul_en,
    output logic                  div_en,
    output alu_op_e               alu_op,
    output mul_op_e               mul_op,
    output div_op_e               div_op,
    output logic                  alu_use_pc,
    output logic                  alu_use_imm,
    output logic [REG_ADDR_W-1:0] rs1_ctrl,
    output logic [REG_ADDR_W-1:0] rs2_ctrl,
    output logic [XLEN-1:0]       pc_ctrl,
    output logic [XLEN-1:0]       imm_ctrl,
    output logic                  reg_write,
    output wb_sel_e               write_sel,
    output logic [REG_ADDR_W-1:0] rd_ctrl
);

    fu_id_e                dec_fu;
    logic [3:0]            dec_op;
    logic [REG_ADDR_W-1:0] dec_dst;
    logic [REG_ADDR_W-1:0] dec_src1;
    logic [REG_ADDR_W-1:0] dec_src2;
    logic                  dec_use_pc;
    logic                  dec_use_imm;

    fu_status_if u_fsi ();

    inst_decoder u_decoder (
        .inst    (inst),
        .fu      (dec_fu),
        .op      (dec_op),
        .dst     (dec_dst),
        .src1    (dec_src1),
        .src2    (dec_src2),
        .use_pc  (dec_use_pc),
        .use_imm (dec_use_imm)
    );

    fu_status_table #(
        .XLEN (XLEN)
    ) u_table (
        .clk      (clk),
        .rst      (rst),
        .fu       (dec_fu),
        .op       (dec_op),
        .dst      (dec_dst),
        .src1     (dec_src1),
        .src2     (dec_src2),
        .use_pc   (dec_use_pc),
        .use_imm  (dec_use_imm),
        .pc       (pc),
        .imm      (imm),
        .alu_done (alu_done),
        .mul_done (mul_done),
        .div_done (div_done),
        .is_en    (is_en),
        .pc_ctrl  (pc_ctrl),
        .imm_ctrl (imm_ctrl),
        .fsi      (u_fsi.tbl)
    );

    operand_arbiter u_operand_arb (
        .fsi         (u_fsi.operand),
        .alu_en      (alu_en),
        .mul_en      (mul_en),
        .div_en      (div_en),
        .alu_op      (alu_op),
        .mul_op      (mul_op),
        .div_op      (div_op),
        .alu_use_pc  (alu_use_pc),
        .alu_use_imm (alu_use_imm),
        .rs1_ctrl    (rs1_ctrl),
        .rs2_ctrl    (rs2_ctrl)
    );

    writeback_arbiter u_writeback_arb (
        .fsi       (u_fsi.writeback),
        .reg_write (reg_write),
        .write_sel (write_sel),
        .rd_ctrl   (rd_ctrl)
    );

endmodule

//--- logic/writeback_arbiter.sv
`timescale 1ns/1ps

module writeback_arbiter import scoreboard_pkg::*; (
    fu_status_if.writeback        fsi,
    output logic                  reg_write,
    output wb_sel_e               write_sel,
    output logic [REG_ADDR_W-1:0] rd_ctrl
);

    logic [NUM_FU:1] war_ok;
    fu_id_e          grant;

    // Blocked while another unit still has to read our destination
    always_comb begin
        for (int u = 1; u <= NUM_FU; u++) begin
            war_ok[u] = 1'b1;
            for (int v = 1; v <= NUM_FU; v++) begin
                if (v != u) begin
                    if (fsi.status[v].rdy1 && fsi.status[v].src1 == fsi.status[u].dst)
                        war_ok[u] = 1'b0;
                    if (fsi.status[v].rdy2 && fsi.status[v].src2 == fsi.status[u].dst)
                        war_ok[u] = 1'b0;
                end
            end
            // x0 is never written
            if (fsi.status[u].dst == '0) war_ok[u] = 1'b1;
        end
    end

    always_comb begin
        grant = FU_NONE;
        for (int u = NUM_FU; u >= 1; u--) begin
            if (fsi.status[u].done && war_ok[u]) grant = fu_id_e'(u);
        end
    end

    assign fsi.wb_grant = grant;

    always_comb begin
        reg_write = 1'b0;
        write_sel = WB_ALU;
        rd_ctrl   = '0;

        case (grant)
            FU_MUL:  write_sel = WB_MUL;
            FU_DIV:  write_sel = WB_DIV;
            default: write_sel = WB_ALU;
        endcase

        // Entry with rd x0 retires without a register write
        if (grant != FU_NONE) begin
            rd_ctrl   = fsi.status[grant].dst;
            reg_write = (rd_ctrl != '0);
        end
    end

endmodule

//--- logic/operand_arbiter.sv
`timescale 1ns/1ps

module operand_arbiter import scoreboard_pkg::*; (
    fu_status_if.operand          fsi,
    output logic                  alu_en,
    output logic                  mul_en,
    output logic                  div_en,
    output alu_op_e               alu_op,
    output mul_op_e               mul_op,
    output div_op_e               div_op,
    output logic                  alu_use_pc,
    output logic                  alu_use_imm,
    output logic [REG_ADDR_W-1:0] rs1_ctrl,
    output logic [REG_ADDR_W-1:0] rs2_ctrl
);

    fu_id_e grant;

    // Lowest tag wins, so ALU before MUL before DIV
    always_comb begin
        grant = FU_NONE;
        for (int u = NUM_FU; u >= 1; u--) begin
            if (fsi.status[u].rdy1 && fsi.status[u].rdy2) grant = fu_id_e'(u);
        end
    end

    assign fsi.ro_grant = grant;

    always_comb begin
        alu_en      = 1'b0;
        mul_en      = 1'b0;
        div_en      = 1'b0;
        alu_op      = ALU_ADD;
        mul_op      = MUL_MUL;
        div_op      = DIV_DIV;
        alu_use_pc  = 1'b0;
        alu_use_imm = 1'b0;
        rs1_ctrl    = '0;
        rs2_ctrl    = '0;

        case (grant)
            FU_ALU: begin
                alu_en      = 1'b1;
                alu_op      = alu_op_e'(fsi.status[FU_ALU].op);
                alu_use_pc  = fsi.status[FU_ALU].use_pc;
                alu_use_imm = fsi.status[FU_ALU].use_imm;
            end
            FU_MUL: begin
                mul_en = 1'b1;
                mul_op = mul_op_e'(fsi.status[FU_MUL].op[1:0]);
            end
            FU_DIV: begin
                div_en = 1'b1;
                div_op = div_op_e'(fsi.status[FU_DIV].op[1:0]);
            end
            default: ;
        endcase

        if (grant != FU_NONE) begin
            rs1_ctrl = fsi.status[grant].src1;
            rs2_ctrl = fsi.status[grant].src2;
        end
    end

endmodule

//--- logic/fu_status_table.sv
`timescale 1ns/1ps

module fu_status_table import scoreboard_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fu_id_e                fu,
    input  logic [3:0]            op,
    input  logic [REG_ADDR_W-1:0] dst,
    input  logic [REG_ADDR_W-1:0] src1,
    input  logic [REG_ADDR_W-1:0] src2,
    input  logic                  use_pc,
    input  logic                  use_imm,
    input  logic [XLEN-1:0]       pc,
    input  logic [XLEN-1:0]       imm,
    input  logic                  alu_done,
    input  logic                  mul_done,
    input  logic                  div_done,
    output logic                  is_en,
    output logic [XLEN-1:0]       pc_ctrl,
    output logic [XLEN-1:0]       imm_ctrl,
    fu_status_if.tbl              fsi
);

    // Register result status, x0 stays FU_NONE
    fu_id_e rrs [2**REG_ADDR_W];

    logic [XLEN-1:0] pc_r  [1:NUM_FU];
    logic [XLEN-1:0] imm_r [1:NUM_FU];

    logic [NUM_FU:0] busy_vec;
    logic [NUM_FU:1] done_vec;
    logic            issue_fire;
    fu_id_e          fu1_tag;
    fu_id_e          fu2_tag;
    fu_status_t      new_rec;

    assign done_vec = {div_done, mul_done, alu_done};

    always_comb begin
        busy_vec[0] = 1'b0;
        for (int u = 1; u <= NUM_FU; u++) begin
            busy_vec[u] = fsi.status[u].busy;
        end
    end

    // Structural and WAW checks; an unknown instruction has fu and dst zero
    assign is_en      = !busy_vec[fu] && (rrs[dst] == FU_NONE);
    assign issue_fire = is_en && (fu != FU_NONE);

    assign fu1_tag = rrs[src1];
    assign fu2_tag = rrs[src2];

    always_comb begin
        new_rec         = '0;
        new_rec.busy    = 1'b1;
        new_rec.op      = op;
        new_rec.use_pc  = use_pc;
        new_rec.use_imm = use_imm;
        new_rec.dst     = dst;
        new_rec.src1    = src1;
        new_rec.src2    = src2;
        // A producer writing back on this same edge counts as ready
        new_rec.rdy1    = (fu1_tag == FU_NONE) || (fu1_tag == fsi.wb_grant);
        new_rec.rdy2    = (fu2_tag == FU_NONE) || (fu2_tag == fsi.wb_grant);
        new_rec.fu1     = new_rec.rdy1 ? FU_NONE : fu1_tag;
        new_rec.fu2     = new_rec.rdy2 ? FU_NONE : fu2_tag;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int u = 1; u <= NUM_FU; u++) begin
                fsi.status[u] <= '0;
            end
            for (int r = 0; r < 2**REG_ADDR_W; r++) begin
                rrs[r] <= FU_NONE;
            end
        end else begin
            for (int u = 1; u <= NUM_FU; u++) begin
                if (done_vec[u]) fsi.status[u].done <= 1'b1;
            end

            // Operands read this cycle
            if (fsi.ro_grant != FU_NONE) begin
                fsi.status[fsi.ro_grant].rdy1 <= 1'b0;
                fsi.status[fsi.ro_grant].rdy2 <= 1'b0;
                fsi.status[fsi.ro_grant].fu1  <= FU_NONE;
                fsi.status[fsi.ro_grant].fu2  <= FU_NONE;
            end

            if (fsi.wb_grant != FU_NONE) begin
                fsi.status[fsi.wb_grant] <= '0;
                rrs[fsi.status[fsi.wb_grant].dst] <= FU_NONE;
                // Wake up RAW consumers
                for (int u = 1; u <= NUM_FU; u++) begin
                    if (fsi.status[u].fu1 == fsi.wb_grant) fsi.status[u].rdy1 <= 1'b1;
                    if (fsi.status[u].fu2 == fsi.wb_grant) fsi.status[u].rdy2 <= 1'b1;
                end
            end

            if (issue_fire) begin
                fsi.status[fu] <= new_rec;
                if (dst != '0) rrs[dst] <= fu;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            pc_r[fu]  <= pc;
            imm_r[fu] <= imm;
        end
    end

    always_comb begin
        pc_ctrl  = '0;
        imm_ctrl = '0;
        if (fsi.ro_grant != FU_NONE) begin
            pc_ctrl  = pc_r[fsi.ro_grant];
            imm_ctrl = imm_r[fsi.ro_grant];
        end
    end

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import scoreboard_pkg::*; (
    input  logic [31:0]           inst,
    output fu_id_e                fu,
    output logic [3:0]            op,
    output logic [REG_ADDR_W-1:0] dst,
    output logic [REG_ADDR_W-1:0] src1,
    output logic [REG_ADDR_W-1:0] src2,
    output logic                  use_pc,
    output logic                  use_imm
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    mul_op_e               mul_sel;
    div_op_e               div_sel;

    assign opcode  = opcode_e'(inst[6:0]);
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign funct7  = inst[31:25];
    assign mul_sel = mul_op_e'(funct3[1:0]);
    assign div_sel = div_op_e'(funct3[1:0]);

    always_comb begin
        fu      = FU_NONE;
        op      = '0;
        dst     = '0;
        src1    = '0;
        src2    = '0;
        use_pc  = 1'b0;
        use_imm = 1'b0;

        case (opcode)
            OPC_OP: begin
                fu = FU_ALU;
                case ({funct7, funct3})
                    {7'h00, 3'd0}: op = ALU_ADD;
                    {7'h20, 3'd0}: op = ALU_SUB;
                    {7'h00, 3'd1}: op = ALU_SLL;
                    {7'h00, 3'd2}: op = ALU_SLT;
                    {7'h00, 3'd3}: op = ALU_SLTU;
                    {7'h00, 3'd4}: op = ALU_XOR;
                    {7'h00, 3'd5}: op = ALU_SRL;
                    {7'h20, 3'd5}: op = ALU_SRA;
                    {7'h00, 3'd6}: op = ALU_OR;
                    {7'h00, 3'd7}: op = ALU_AND;
                    default: begin
                        if (funct7 == 7'h01 && funct3[2]) begin
                            fu = FU_DIV;
                            op = {2'b00, div_sel};
                        end else if (funct7 == 7'h01) begin
                            fu = FU_MUL;
                            op = {2'b00, mul_sel};
                        end else begin
                            fu = FU_NONE;
                        end
                    end
                endcase
                if (fu != FU_NONE) begin
                    dst  = rd;
                    src1 = rs1;
                    src2 = rs2;
                end
            end
            OPC_OP_IMM: begin
                fu = FU_ALU;
                case (funct3)
                    3'd0: op = ALU_ADD;
                    3'd2: op = ALU_SLT;
                    3'd3: op = ALU_SLTU;
                    3'd4: op = ALU_XOR;
                    3'd6: op = ALU_OR;
                    3'd7: op = ALU_AND;
                    3'd1: begin
                        op = ALU_SLL;
                        if (funct7 != 7'h00) fu = FU_NONE;
                    end
                    default: begin
                        // Shift right, arithmetic when bit 30 is set
                        if (funct7 == 7'h00) op = ALU_SRL;
                        else if (funct7 == 7'h20) op = ALU_SRA;
                        else fu = FU_NONE;
                    end
                endcase
                if (fu != FU_NONE) begin
                    dst     = rd;
                    src1    = rs1;
                    use_imm = 1'b1;
                end else begin
                    op = '0;
                end
            end
            OPC_LUI: begin
                fu      = FU_ALU;
                op      = ALU_LUI;
                dst     = rd;
                use_imm = 1'b1;
            end
            OPC_AUIPC: begin
                // pc + imm on the adder
                fu      = FU_ALU;
                op      = ALU_ADD;
                dst     = rd;
                use_pc  = 1'b1;
                use_imm = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/fu_status_if.sv
`timescale 1ns/1ps

interface fu_status_if import scoreboard_pkg::*; ();

    // One record per unit, indexed by fu_id_e
    fu_status_t status [1:NUM_FU];

    // FU_NONE when nobody is granted
    fu_id_e ro_grant;
    fu_id_e wb_grant;

    modport tbl (
        output status,
        input  ro_grant,
        input  wb_grant
    );

    modport operand (
        input  status,
        output ro_grant
    );

    modport writeback (
        input  status,
        output wb_grant
    );

endinterface

//--- logic/scoreboard_pkg.sv
package scoreboard_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int NUM_FU = 3;

    // Unit tags, also used as register result status entries
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MUL  = 2'd2,
        FU_DIV  = 2'd3
    } fu_id_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_e;

    // Same order as funct3[1:0] of the M extension
    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_e;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MUL = 2'd1,
        WB_DIV = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic                  busy;
        logic [3:0]            op;
        logic                  use_pc;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] dst;
        logic [REG_ADDR_W-1:0] src1;
        logic [REG_ADDR_W-1:0] src2;
        fu_id_e                fu1;
        fu_id_e                fu2;
        logic                  rdy1;
        logic                  rdy2;
        logic                  done;
    } fu_status_t;

endpackage
